//--- verilog/basket_pkg.sv
////////////////////
// Basket package
// Widths, slot and command types, the empty-slot marker
// and the fixed unit-price table of the basket controller
////////////////////

`default_nettype none

package basket_pkg;

	localparam int ID_W = 4;
	localparam int QTY_W = 4;
	localparam int PRICE_W = 16;
	localparam int TOTAL_W = 20;

	// An empty slot has every field all ones
	localparam logic [ID_W-1:0] EMPTY_ID = ID_W'(15);

	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_ADD = 2'd1,
		OP_CANCEL = 2'd2
	} basket_op_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [QTY_W-1:0] qty;
		logic [PRICE_W-1:0] price;
	} basket_entry_t;

	// Id is the product id on an add and the slot position on a cancel
	typedef struct packed {
		basket_op_t op;
		logic [ID_W-1:0] id;
		logic [QTY_W-1:0] qty;
	} basket_cmd_t;

	typedef struct packed {
		basket_cmd_t cmd;
		logic [PRICE_W-1:0] price;
	} priced_cmd_t;

	// Unit prices by product id, id 15 is never stored
	localparam logic [PRICE_W-1:0] UNIT_PRICE [1 << ID_W] = '{
		16'd120, 16'd45, 16'd999, 16'd310,
		16'd75, 16'd580, 16'd12, 16'd260,
		16'd899, 16'd150, 16'd33, 16'd470,
		16'd640, 16'd5, 16'd725, 16'd0
	};

endpackage

`default_nettype wire

//--- verilog/basket_cmd_decode.sv
////////////////////
// Basket command decode
// Validates add and cancel strobes against the item count,
// keeps the count and issues one command per accepted request
////////////////////

`default_nettype none

module basket_cmd_decode #(
	parameter int MAX_ITEMS = 12
) (
	input wire CLK,
	input wire RESET_N,
	input wire enable,
	input wire cancel,
	input wire [basket_pkg::ID_W-1:0] id,
	input wire [basket_pkg::QTY_W-1:0] qtt,
	output logic [basket_pkg::ID_W-1:0] num,
	output basket_pkg::basket_cmd_t cmd
);

	import basket_pkg::*;

	logic add_ok;
	logic cancel_ok;
	logic [ID_W-1:0] count_q;
	basket_op_t op_q;
	logic [ID_W-1:0] id_q;
	logic [QTY_W-1:0] qty_q;

	// Both strobes high together is treated as no request
	assign add_ok = enable && !cancel && (count_q < ID_W'(MAX_ITEMS)) && (id != EMPTY_ID);
	assign cancel_ok = cancel && !enable && (id < count_q);

	// Count includes commands still in flight, so later requests see the final fill level
	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			count_q <= '0;
			op_q <= OP_NONE;
		end else if (add_ok) begin
			count_q <= count_q + 1'b1;
			op_q <= OP_ADD;
		end else if (cancel_ok) begin
			count_q <= count_q - 1'b1;
			op_q <= OP_CANCEL;
		end else begin
			op_q <= OP_NONE;
		end
	end

	always_ff @(posedge CLK) begin
		id_q <= id;
		qty_q <= qtt;
	end

	assign cmd = '{op: op_q, id: id_q, qty: qty_q};
	assign num = count_q;

endmodule

`default_nettype wire

//--- verilog/price_calc.sv
////////////////////
// Price calculator
// Execute stage of the basket pipeline. Looks up the unit
// price of the product and multiplies it by the quantity
////////////////////

`default_nettype none

module price_calc (
	input wire CLK,
	input wire RESET_N,
	input wire basket_pkg::basket_cmd_t cmd,
	output basket_pkg::priced_cmd_t priced
);

	import basket_pkg::*;

	logic [PRICE_W-1:0] unit_price;
	logic [PRICE_W-1:0] line_price;
	basket_op_t op_q;
	logic [ID_W-1:0] id_q;
	logic [QTY_W-1:0] qty_q;
	logic [PRICE_W-1:0] price_q;

	// On a cancel the id is a position, so the lookup result is dropped
	assign unit_price = UNIT_PRICE[cmd.id];

	// Product truncated to the price width
	assign line_price = (cmd.op == OP_ADD) ? PRICE_W'(unit_price * cmd.qty) : '0;

	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			op_q <= OP_NONE;
		end else begin
			op_q <= cmd.op;
		end
	end

	always_ff @(posedge CLK) begin
		id_q <= cmd.id;
		qty_q <= cmd.qty;
		price_q <= line_price;
	end

	assign priced = '{
		cmd: '{op: op_q, id: id_q, qty: qty_q},
		price: price_q
	};

endmodule

`default_nettype wire

//--- verilog/basket_list.sv
////////////////////
// Basket list
// Result stage holding the basket slots. Appends added
// products, closes the gap left by a cancel and keeps
// the running total of all line prices
////////////////////

`default_nettype none

module basket_list #(
	parameter int MAX_ITEMS = 12
) (
	input wire CLK,
	input wire RESET_N,
	input wire basket_pkg::priced_cmd_t priced,
	output basket_pkg::basket_entry_t items [MAX_ITEMS],
	output logic [basket_pkg::TOTAL_W-1:0] total_price
);

	import basket_pkg::*;

	localparam basket_entry_t EMPTY_ENTRY = '{id: EMPTY_ID, qty: '1, price: '1};

	basket_entry_t new_entry;
	basket_entry_t shifted [MAX_ITEMS];
	logic [ID_W-1:0] wr_ptr;
	logic [ID_W-1:0] pos;
	logic [PRICE_W-1:0] removed_price;
	logic [TOTAL_W-1:0] total_q;

	assign pos = priced.cmd.id;
	assign new_entry = '{id: priced.cmd.id, qty: priced.cmd.qty, price: priced.price};

	// Commands arrive validated, so pos always points at a filled slot
	assign removed_price = items[pos].price;

	// Every slot seen one place down, the top slot becomes empty
	always_comb begin
		for (int i = 0; i < MAX_ITEMS - 1; i++) begin
			shifted[i] = items[i + 1];
		end
		shifted[MAX_ITEMS - 1] = EMPTY_ENTRY;
	end

	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			for (int i = 0; i < MAX_ITEMS; i++) begin
				items[i] <= EMPTY_ENTRY;
			end
			wr_ptr <= '0;
			total_q <= '0;
		end else begin
			case (priced.cmd.op)
				OP_ADD: begin
					items[wr_ptr] <= new_entry;
					wr_ptr <= wr_ptr + 1'b1;
					total_q <= total_q + TOTAL_W'(priced.price);
				end
				OP_CANCEL: begin
					// Slots below the cancelled one keep their place
					for (int i = 0; i < MAX_ITEMS; i++) begin
						if (ID_W'(i) >= pos) begin
							items[i] <= shifted[i];
						end
					end
					wr_ptr <= wr_ptr - 1'b1;
					total_q <= total_q - TOTAL_W'(removed_price);
				end
				default: begin
					wr_ptr <= wr_ptr;
				end
			endcase
		end
	end

	assign total_price = total_q;

endmodule

`default_nettype wire

//--- verilog/basket_controller.sv
////////////////////
// Basket controller
// Top level of the shopping basket. Requests pass through
// decode, price calculation and the slot list in turn
////////////////////

`default_nettype none

module basket_controller #(
	parameter int MAX_ITEMS = 12
) (
	input wire CLK,
	input wire RESET_N,
	input wire enable,
	input wire cancel,
	input wire [basket_pkg::ID_W-1:0] id,
	input wire [basket_pkg::QTY_W-1:0] qtt,
	output logic [basket_pkg::ID_W-1:0] num,
	output logic [basket_pkg::TOTAL_W-1:0] total_price,
	output basket_pkg::basket_entry_t items [MAX_ITEMS]
);

	import basket_pkg::*;

	basket_cmd_t cmd;
	priced_cmd_t priced;

	basket_cmd_decode #(
		.MAX_ITEMS(MAX_ITEMS)
	) i_decode (
		.CLK(CLK),
		.RESET_N(RESET_N),
		.enable(enable),
		.cancel(cancel),
		.id(id),
		.qtt(qtt),
		.num(num),
		.cmd(cmd)
	);

	price_calc i_price_calc (
		.CLK(CLK),
		.RESET_N(RESET_N),
		.cmd(cmd),
		.priced(priced)
	);

	basket_list #(
		.MAX_ITEMS(MAX_ITEMS)
	) i_list (
		.CLK(CLK),
		.RESET_N(RESET_N),
		.priced(priced),
		.items(items),
		.total_price(total_price)
	);

endmodule

`default_nettype wire

//--- bench/tb_basket_tasks.svh
////////////////////
// Basket testbench tasks
// Check helpers and the directed tests
////////////////////

`ifndef TB_BASKET_TASKS_SVH
`define TB_BASKET_TASKS_SVH

task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
	assert (exp == act) else begin
		failed = 1'b1;
		$display("[FAIL] %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
		stop_failed();
	end
endtask

task automatic check_slot(input int i, input basket_entry_t exp);
	check_value($sformatf("slot %0d", i), 32'(exp), 32'(items[i]));
endtask

task automatic drive_request(input logic en, input logic can,
		input logic [ID_W-1:0] pid, input logic [QTY_W-1:0] q);
	enable <= en;
	cancel <= can;
	id <= pid;
	qtt <= q;
	@(posedge CLK);
endtask

// Idles the inputs until the list has caught up with the model, ends at a falling edge
task automatic wait_settled();
	int cycles;
	logic done;
	cycles = 0;
	done = 1'b0;
	enable <= 1'b0;
	cancel <= 1'b0;
	while (!done && cycles < SETTLE_CYCLES) begin
		@(negedge CLK);
		done = (total_price == m_total) && (num == m_num);
		for (int i = 0; i < MAX_ITEMS; i++) begin
			if (items[i] != m_items[i]) begin
				done = 1'b0;
			end
		end
		cycles++;
	end
	if (!done) begin
		failed = 1'b1;
		$display("Timeout in %s: basket did not settle within %0d cycles", test_name, SETTLE_CYCLES);
		stop_failed();
	end
endtask

// Fill pattern, distinct ids and quantities 1 to 12
function automatic logic [ID_W-1:0] fill_id(input int i);
	return ID_W'((i * 7 + 2) % 15);
endfunction

function automatic logic [QTY_W-1:0] fill_qty(input int i);
	return QTY_W'(i % 15 + 1);
endfunction

function automatic basket_entry_t fill_entry(input int i);
	return make_entry(fill_id(i), fill_qty(i));
endfunction

// Slot contents once position 4 has been removed from the full basket
function automatic basket_entry_t cancelled_entry(input int i);
	return fill_entry(i < 4 ? i : i + 1);
endfunction

task automatic test_reset_state();
	test_name = "reset";
	@(negedge CLK);
	check_value("num", 32'd0, 32'(num));
	check_value("total_price", 32'd0, 32'(total_price));
	for (int i = 0; i < MAX_ITEMS; i++) begin
		check_slot(i, '1);
	end
	@(posedge CLK);
endtask

task automatic test_fill();
	logic [TOTAL_W-1:0] exp_total;
	basket_entry_t e;
	test_name = "fill";
	exp_total = '0;
	for (int i = 0; i < MAX_ITEMS; i++) begin
		e = fill_entry(i);
		exp_total = exp_total + TOTAL_W'(e.price);
		drive_request(1'b1, 1'b0, fill_id(i), fill_qty(i));
	end
	wait_settled();
	check_value("num", 32'(MAX_ITEMS), 32'(num));
	check_value("total_price", 32'(exp_total), 32'(total_price));
	for (int i = 0; i < MAX_ITEMS; i++) begin
		check_slot(i, fill_entry(i));
	end
	@(posedge CLK);
endtask

task automatic test_cancel_middle();
	logic [TOTAL_W-1:0] exp_total;
	basket_entry_t e;
	test_name = "cancel";
	exp_total = '0;
	for (int i = 0; i < MAX_ITEMS - 1; i++) begin
		e = cancelled_entry(i);
		exp_total = exp_total + TOTAL_W'(e.price);
	end
	drive_request(1'b0, 1'b1, ID_W'(4), '0);
	wait_settled();
	check_value("num", 32'(MAX_ITEMS - 1), 32'(num));
	check_value("total_price", 32'(exp_total), 32'(total_price));
	for (int i = 0; i < MAX_ITEMS - 1; i++) begin
		check_slot(i, cancelled_entry(i));
	end
	check_slot(MAX_ITEMS - 1, '1);
	@(posedge CLK);
endtask

task automatic test_ignored();
	logic [TOTAL_W-1:0] exp_total;
	basket_entry_t e;
	test_name = "ignored";
	exp_total = '0;
	for (int i = 0; i < MAX_ITEMS - 1; i++) begin
		e = cancelled_entry(i);
		exp_total = exp_total + TOTAL_W'(e.price);
	end
	drive_request(1'b1, 1'b0, EMPTY_ID, QTY_W'(3));
	drive_request(1'b0, 1'b1, ID_W'(MAX_ITEMS - 1), '0);
	drive_request(1'b0, 1'b1, ID_W'(14), '0);
	drive_request(1'b1, 1'b1, ID_W'(0), QTY_W'(2));
	wait_settled();
	check_value("num", 32'(MAX_ITEMS - 1), 32'(num));
	check_value("total_price", 32'(exp_total), 32'(total_price));
	for (int i = 0; i < MAX_ITEMS - 1; i++) begin
		check_slot(i, cancelled_entry(i));
	end
	check_slot(MAX_ITEMS - 1, '1);
	@(posedge CLK);
	// Refill the last slot, then try one more add on the full basket
	e = make_entry(ID_W'(10), QTY_W'(7));
	exp_total = exp_total + TOTAL_W'(e.price);
	drive_request(1'b1, 1'b0, ID_W'(10), QTY_W'(7));
	drive_request(1'b1, 1'b0, ID_W'(3), QTY_W'(5));
	wait_settled();
	check_value("num", 32'(MAX_ITEMS), 32'(num));
	check_value("total_price", 32'(exp_total), 32'(total_price));
	check_slot(MAX_ITEMS - 1, e);
	@(posedge CLK);
endtask

task automatic test_random();
	logic [31:0] sel;
	logic [31:0] pid;
	logic [31:0] q;
	logic en;
	logic can;
	test_name = "random";
	for (int n = 0; n < RANDOM_CYCLES; n++) begin
		sel = take_bits(3);
		pid = take_bits(ID_W);
		q = take_bits(QTY_W);
		en = (sel[2:0] < 3'd3) || (sel[2:0] == 3'd6);
		can = (sel[2:0] >= 3'd3) && (sel[2:0] != 3'd7);
		drive_request(en, can, ID_W'(pid), QTY_W'(q));
	end
	wait_settled();
	@(posedge CLK);
endtask

`endif

//--- bench/tb_basket.sv
////////////////////
// Basket controller testbench
// Drives directed and random requests into the basket
// controller and checks count, slots and total against
// a reference model of the basket rules
////////////////////

`default_nettype none

module tb_basket;

	import basket_pkg::*;

	localparam int MAX_ITEMS = 12;
	// Slots and total follow the count two clock edges later
	localparam int LIST_LAG = 2;
	localparam int SETTLE_CYCLES = 20;
	localparam int RANDOM_CYCLES = 200;

	logic CLK;
	logic RESET_N;
	logic enable;
	logic cancel;
	logic [ID_W-1:0] id;
	logic [QTY_W-1:0] qtt;
	logic [ID_W-1:0] num;
	logic [TOTAL_W-1:0] total_price;
	basket_entry_t items [MAX_ITEMS];

	// Reference model, current state and delayed copies for the list
	basket_entry_t m_items [MAX_ITEMS];
	logic [TOTAL_W-1:0] m_total;
	logic [ID_W-1:0] m_num;
	basket_entry_t hist_items [LIST_LAG][MAX_ITEMS];
	logic [TOTAL_W-1:0] hist_total [LIST_LAG];

	logic [31:0] lfsr;
	string test_name;
	logic failed;

	basket_controller #(
		.MAX_ITEMS(MAX_ITEMS)
	) i_dut (
		.CLK(CLK),
		.RESET_N(RESET_N),
		.enable(enable),
		.cancel(cancel),
		.id(id),
		.qtt(qtt),
		.num(num),
		.total_price(total_price),
		.items(items)
	);

	`include "tb_basket_tasks.svh"

	initial begin
		CLK = 1'b0;
		forever begin
			#4 CLK = ~CLK;
		end
	end

	task automatic stop_failed();
		$display("Test failed");
		$fatal(1, "Simulation stopped after a failed check");
	endtask

	// Fibonacci LFSR with taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic basket_entry_t make_entry(input logic [ID_W-1:0] pid,
			input logic [QTY_W-1:0] q);
		basket_entry_t e;
		e.id = pid;
		e.qty = q;
		e.price = PRICE_W'(int'(UNIT_PRICE[pid]) * int'(q));
		return e;
	endfunction

	task automatic model_apply(input logic en, input logic can,
			input logic [ID_W-1:0] pid, input logic [QTY_W-1:0] q);
		if (en && !can && int'(m_num) < MAX_ITEMS && pid != EMPTY_ID) begin
			m_items[m_num] = make_entry(pid, q);
			m_total = m_total + TOTAL_W'(m_items[m_num].price);
			m_num = m_num + ID_W'(1);
		end else if (can && !en && pid < m_num) begin
			m_total = m_total - TOTAL_W'(m_items[pid].price);
			for (int i = int'(pid); i < MAX_ITEMS - 1; i++) begin
				m_items[i] = m_items[i + 1];
			end
			m_items[MAX_ITEMS - 1] = '1;
			m_num = m_num - ID_W'(1);
		end
	endtask

	// Model sees the inputs as the DUT samples them
	always @(posedge CLK) begin
		if (!RESET_N) begin
			m_num = '0;
			m_total = '0;
			for (int i = 0; i < MAX_ITEMS; i++) begin
				m_items[i] = '1;
				for (int k = 0; k < LIST_LAG; k++) begin
					hist_items[k][i] = '1;
				end
			end
			for (int k = 0; k < LIST_LAG; k++) begin
				hist_total[k] = '0;
			end
		end else begin
			for (int k = LIST_LAG - 1; k > 0; k--) begin
				hist_total[k] = hist_total[k - 1];
				for (int i = 0; i < MAX_ITEMS; i++) begin
					hist_items[k][i] = hist_items[k - 1][i];
				end
			end
			hist_total[0] = m_total;
			for (int i = 0; i < MAX_ITEMS; i++) begin
				hist_items[0][i] = m_items[i];
			end
			model_apply(enable, cancel, id, qtt);
		end
	end

	// Cycle by cycle comparison at the falling edge
	always @(negedge CLK) begin
		if (RESET_N) begin
			check_value("num", 32'(m_num), 32'(num));
			check_value("total_price", 32'(hist_total[LIST_LAG - 1]), 32'(total_price));
			for (int i = 0; i < MAX_ITEMS; i++) begin
				check_slot(i, hist_items[LIST_LAG - 1][i]);
			end
		end
	end

	initial begin
		failed = 1'b0;
		lfsr = 32'hc04f2e95;
		test_name = "reset";
		RESET_N = 1'b0;
		enable = 1'b0;
		cancel = 1'b0;
		id = '0;
		qtt = '0;
		repeat (3) begin
			@(posedge CLK);
		end
		RESET_N <= 1'b1;
		test_reset_state();
		test_fill();
		test_cancel_middle();
		test_ignored();
		test_random();
		if (!failed) begin
			$display("Test passed");
			$finish;
		end else begin
			stop_failed();
		end
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+bench
verilog/basket_pkg.sv
verilog/basket_cmd_decode.sv
verilog/price_calc.sv
verilog/basket_list.sv
verilog/basket_controller.sv
bench/tb_basket.sv

//--- Makefile
TOP = tb_basket
OBJ = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ) -f sim.f

run: compile
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
